//--- Bender.yml
package:
  name: l2_coh

sources:
  - src/l2_coh_pkg.sv
  - src/l2_dir_store.sv
  - src/l2_dir_lookup.sv
  - src/l2_probe_ctrl.sv
  - src/l2_xact_fsm.sv
  - src/l2_coh_top.sv
  - target: test
    files:
      - verif/l2_coh_tb.sv

//--- all.f
src/l2_coh_pkg.sv
src/l2_dir_store.sv
src/l2_dir_lookup.sv
src/l2_probe_ctrl.sv
src/l2_xact_fsm.sv
src/l2_coh_top.sv
verif/l2_coh_tb.sv

//--- src/l2_coh_pkg.sv
package l2_coh_pkg;

    // Geometry
    localparam int NUM_CORES  = 4;
    localparam int CORE_ID_W  = 2;
    localparam int NUM_WAYS   = 4;
    localparam int WAY_W      = 2;
    localparam int NUM_SETS   = 16;
    localparam int SET_W      = 4;
    localparam int LINE_OFS_W = 6;   // 64-byte lines
    localparam int ADDR_W     = 32;
    localparam int TAG_W      = ADDR_W - SET_W - LINE_OFS_W;
    localparam int SOURCE_W   = 6;   // Core id sits in the top bits

    // Channel opcodes
    localparam logic [2:0] A_ACQUIRE_BLOCK = 3'd6;
    localparam logic [2:0] A_ACQUIRE_PERM  = 3'd7;
    localparam logic [2:0] B_PROBE_BLOCK   = 3'd6;
    localparam logic [2:0] B_PROBE_PERM    = 3'd7;
    localparam logic [2:0] C_PROBE_ACK     = 3'd4;
    localparam logic [2:0] D_GRANT         = 3'd4;
    localparam logic [2:0] D_GRANT_DATA    = 3'd5;

    // Acquire grow params
    localparam logic [2:0] GROW_NTOB = 3'd0;
    localparam logic [2:0] GROW_NTOT = 3'd1;
    localparam logic [2:0] GROW_BTOT = 3'd2;

    // Capabilities for probe and grant params
    localparam logic [2:0] CAP_TO_T = 3'd0;
    localparam logic [2:0] CAP_TO_B = 3'd1;
    localparam logic [2:0] CAP_TO_N = 3'd2;

    typedef struct packed {
        logic [2:0]          opcode;
        logic [2:0]          param;
        logic [SOURCE_W-1:0] source;
        logic [ADDR_W-1:0]   address;
    } acq_req_t;

    // One directory way
    typedef struct packed {
        logic                 valid;
        logic [TAG_W-1:0]     tag;
        logic [NUM_CORES-1:0] sharers;
        logic                 owner_valid;
        logic [CORE_ID_W-1:0] owner_id;
    } dir_entry_t;

    typedef struct packed {
        logic [2:0]           opcode;
        logic [2:0]           param;
        logic [ADDR_W-1:0]    address;
        logic [CORE_ID_W-1:0] dest;   // Target core
    } probe_t;

    typedef struct packed {
        logic [2:0]          opcode;
        logic [2:0]          param;
        logic [SOURCE_W-1:0] source;
    } grant_t;

endpackage

//--- src/l2_coh_top.sv
`timescale 1ns/10ps

module l2_coh_top (
    input  logic                             clk_i,
    input  logic                             rst_ni,

    // A: Acquire
    input  l2_coh_pkg::acq_req_t             a_req_i,
    input  logic                             a_valid_i,
    output logic                             a_ready_o,

    // B: probes
    output l2_coh_pkg::probe_t               b_probe_o,
    output logic                             b_valid_o,
    input  logic                             b_ready_i,

    // C: ProbeAck
    input  logic [2:0]                       c_opcode_i,
    input  logic [l2_coh_pkg::SOURCE_W-1:0]  c_source_i,
    input  logic                             c_valid_i,
    output logic                             c_ready_o,

    // D: grant
    output l2_coh_pkg::grant_t               d_grant_o,
    output logic                             d_valid_o,
    input  logic                             d_ready_i,

    // E: GrantAck strobe
    input  logic                             e_valid_i
);
    import l2_coh_pkg::*;

    dir_entry_t [NUM_WAYS-1:0] rd_ways;
    logic [SET_W-1:0]          rd_set;
    logic [TAG_W-1:0]          tag;
    logic                      lk_hit;
    logic [WAY_W-1:0]          lk_way;
    dir_entry_t                lk_entry;
    logic                      lk_evict;
    logic                      alloc;
    logic                      we;
    logic [SET_W-1:0]          wr_set;
    logic [WAY_W-1:0]          wr_way;
    dir_entry_t                wr_entry;
    logic                      probe_start;
    logic                      probe_done;
    acq_req_t                  req;
    logic                      pr_hit;
    dir_entry_t                pr_entry;

    l2_dir_store i_l2_dir_store (
        .clk_i, .rst_ni,
        .rd_set_i (rd_set),   .rd_ways_o (rd_ways),
        .we_i     (we),       .wr_set_i  (wr_set),
        .wr_way_i (wr_way),   .wr_entry_i(wr_entry)
    );

    l2_dir_lookup i_l2_dir_lookup (
        .clk_i, .rst_ni,
        .tag_i  (tag),      .ways_i (rd_ways),  .alloc_i(alloc),
        .hit_o  (lk_hit),   .way_o  (lk_way),
        .entry_o(lk_entry), .evict_o(lk_evict)
    );

    l2_probe_ctrl i_l2_probe_ctrl (
        .clk_i, .rst_ni,
        .start_i(probe_start), .req_i(req), .hit_i(pr_hit), .entry_i(pr_entry),
        .set_i  (rd_set),      .done_o(probe_done),
        .b_probe_o, .b_valid_o, .b_ready_i,
        .c_opcode_i, .c_source_i, .c_valid_i, .c_ready_o
    );

    l2_xact_fsm i_l2_xact_fsm (
        .clk_i, .rst_ni,
        .a_req_i, .a_valid_i, .a_ready_o,
        .hit_i  (lk_hit),   .way_i   (lk_way),
        .entry_i(lk_entry), .evict_i (lk_evict),
        .rd_set_o(rd_set),  .tag_o   (tag),      .alloc_o(alloc),
        .we_o    (we),      .wr_set_o(wr_set),   .wr_way_o(wr_way), .wr_entry_o(wr_entry),
        .probe_start_o(probe_start), .req_o(req), .hit_o(pr_hit), .entry_o(pr_entry),
        .probe_done_i (probe_done),
        .d_grant_o, .d_valid_o, .d_ready_i, .e_valid_i
    );

endmodule

//--- src/l2_dir_lookup.sv
`timescale 1ns/10ps

module l2_dir_lookup (
    input  logic                                              clk_i,
    input  logic                                              rst_ni,
    input  logic [l2_coh_pkg::TAG_W-1:0]                      tag_i,
    input  l2_coh_pkg::dir_entry_t [l2_coh_pkg::NUM_WAYS-1:0] ways_i,
    input  logic                                              alloc_i,   // Advance victim
    output logic                                              hit_o,
    output logic [l2_coh_pkg::WAY_W-1:0]                      way_o,
    output l2_coh_pkg::dir_entry_t                            entry_o,
    output logic                                              evict_o
);
    import l2_coh_pkg::*;

    logic [WAY_W-1:0]    rr_q;      // Round-robin victim pointer
    logic [NUM_WAYS-1:0] match;
    logic [NUM_WAYS-1:0] free;
    logic [WAY_W-1:0]    hit_way;
    logic [WAY_W-1:0]    free_way;
    logic                any_free;

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            match[w] = ways_i[w].valid && (ways_i[w].tag == tag_i);
            free[w]  = !ways_i[w].valid;
        end
    end

    // Walk downward so the lowest index wins
    always_comb begin
        hit_way  = '0;
        free_way = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (match[w]) begin
                hit_way = WAY_W'(w);
            end
            if (free[w]) begin
                free_way = WAY_W'(w);
            end
        end
    end

    assign any_free = |free;
    assign hit_o    = |match;
    assign evict_o  = !hit_o && !any_free;   // Set full, victim must go

    always_comb begin
        if (hit_o) begin
            way_o = hit_way;
        end else if (any_free) begin
            way_o = free_way;
        end else begin
            way_o = rr_q;
        end
    end

    assign entry_o = ways_i[way_o];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rr_q <= '0;
        end else if (alloc_i) begin
            rr_q <= (rr_q == WAY_W'(NUM_WAYS - 1)) ? '0 : rr_q + 1'b1;
        end
    end

endmodule

//--- src/l2_dir_store.sv
`timescale 1ns/10ps

module l2_dir_store (
    input  logic                                              clk_i,
    input  logic                                              rst_ni,

    // Read port, combinational
    input  logic [l2_coh_pkg::SET_W-1:0]                      rd_set_i,
    output l2_coh_pkg::dir_entry_t [l2_coh_pkg::NUM_WAYS-1:0] rd_ways_o,

    // Write port, one way per cycle
    input  logic                                              we_i,
    input  logic [l2_coh_pkg::SET_W-1:0]                      wr_set_i,
    input  logic [l2_coh_pkg::WAY_W-1:0]                      wr_way_i,
    input  l2_coh_pkg::dir_entry_t                            wr_entry_i
);
    import l2_coh_pkg::*;

    dir_entry_t [NUM_WAYS-1:0] dir_q [NUM_SETS];

    // Whole set comes out at once for the tag compare
    assign rd_ways_o = dir_q[rd_set_i];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                dir_q[s] <= '0;   // All ways invalid
            end
        end else if (we_i) begin
            dir_q[wr_set_i][wr_way_i] <= wr_entry_i;
        end
    end

endmodule

//--- src/l2_probe_ctrl.sv
`timescale 1ns/10ps

module l2_probe_ctrl (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,

    // From the transaction FSM
    input  logic                                 start_i,
    input  l2_coh_pkg::acq_req_t                 req_i,
    input  logic                                 hit_i,
    input  l2_coh_pkg::dir_entry_t               entry_i,
    input  logic [l2_coh_pkg::SET_W-1:0]         set_i,
    output logic                                 done_o,

    // B channel
    output l2_coh_pkg::probe_t                   b_probe_o,
    output logic                                 b_valid_o,
    input  logic                                 b_ready_i,

    // C channel, ProbeAck only
    input  logic [2:0]                           c_opcode_i,
    input  logic [l2_coh_pkg::SOURCE_W-1:0]      c_source_i,
    input  logic                                 c_valid_i,
    output logic                                 c_ready_o
);
    import l2_coh_pkg::*;

    logic [NUM_CORES-1:0] targets;
    logic [NUM_CORES-1:0] owner_oh;
    logic [NUM_CORES-1:0] req_oh;
    logic [NUM_CORES-1:0] send_q;   // Still to be issued on B
    logic [NUM_CORES-1:0] pend_q;   // Still awaiting ProbeAck
    logic [NUM_CORES-1:0] send_n;
    logic [NUM_CORES-1:0] pend_n;
    logic [NUM_CORES-1:0] b_oh;
    logic [NUM_CORES-1:0] ack_oh;
    logic [CORE_ID_W-1:0] req_core;
    logic [CORE_ID_W-1:0] ack_core;
    logic [CORE_ID_W-1:0] dest;
    logic [2:0]           opcode_q;
    logic [2:0]           param_q;
    logic [ADDR_W-1:0]    addr_q;
    logic                 is_ntob;

    assign req_core = req_i.source[SOURCE_W-1 -: CORE_ID_W];
    assign req_oh   = NUM_CORES'(1) << req_core;
    assign owner_oh = entry_i.owner_valid ? (NUM_CORES'(1) << entry_i.owner_id) : '0;
    assign is_ntob  = (req_i.opcode == A_ACQUIRE_BLOCK) && (req_i.param == GROW_NTOB);

    always_comb begin
        targets = '0;
        if (hit_i) begin
            // NtoB only downgrades an owner
            targets = is_ntob ? owner_oh : (entry_i.sharers | owner_oh);
            targets = targets & ~req_oh;
        end else if (entry_i.valid) begin
            targets = entry_i.sharers | owner_oh;   // Every holder of the victim
        end
    end

    // Lowest pending target goes first
    always_comb begin
        dest = '0;
        for (int c = NUM_CORES - 1; c >= 0; c--) begin
            if (send_q[c]) begin
                dest = CORE_ID_W'(c);
            end
        end
    end

    assign b_valid_o = |send_q;
    assign b_probe_o = '{opcode: opcode_q, param: param_q, address: addr_q, dest: dest};
    assign b_oh      = (b_valid_o && b_ready_i) ? (NUM_CORES'(1) << dest) : '0;

    // Acks from cores not pending simply clear nothing
    assign c_ready_o = 1'b1;
    assign ack_core  = c_source_i[SOURCE_W-1 -: CORE_ID_W];
    assign ack_oh    = (c_valid_i && c_opcode_i == C_PROBE_ACK) ?
                       (NUM_CORES'(1) << ack_core) : '0;

    assign send_n = send_q & ~b_oh;
    assign pend_n = pend_q & ~ack_oh;

    // Pulse on the cycle both masks drain, or at once with nothing to probe
    assign done_o = start_i ? (targets == '0) :
                    ((|send_q || |pend_q) && send_n == '0 && pend_n == '0);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            send_q <= '0;
            pend_q <= '0;
        end else if (start_i) begin
            send_q <= targets;
            pend_q <= targets;
        end else begin
            send_q <= send_n;
            pend_q <= pend_n;
        end
    end

    // Probe fields; hit line and victim line share the same address form
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            opcode_q <= (hit_i && req_i.opcode == A_ACQUIRE_PERM) ? B_PROBE_PERM : B_PROBE_BLOCK;
            param_q  <= (hit_i && is_ntob) ? CAP_TO_B : CAP_TO_N;
            addr_q   <= {entry_i.tag, set_i, LINE_OFS_W'(0)};
        end
    end

endmodule

//--- src/l2_xact_fsm.sv
`timescale 1ns/10ps

module l2_xact_fsm (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,

    // A channel
    input  l2_coh_pkg::acq_req_t                 a_req_i,
    input  logic                                 a_valid_i,
    output logic                                 a_ready_o,

    // Lookup result
    input  logic                                 hit_i,
    input  logic [l2_coh_pkg::WAY_W-1:0]         way_i,
    input  l2_coh_pkg::dir_entry_t               entry_i,
    input  logic                                 evict_i,
    output logic [l2_coh_pkg::SET_W-1:0]         rd_set_o,
    output logic [l2_coh_pkg::TAG_W-1:0]         tag_o,
    output logic                                 alloc_o,

    // Directory write
    output logic                                 we_o,
    output logic [l2_coh_pkg::SET_W-1:0]         wr_set_o,
    output logic [l2_coh_pkg::WAY_W-1:0]         wr_way_o,
    output l2_coh_pkg::dir_entry_t               wr_entry_o,

    // Probe block
    output logic                                 probe_start_o,
    output l2_coh_pkg::acq_req_t                 req_o,
    output logic                                 hit_o,
    output l2_coh_pkg::dir_entry_t               entry_o,
    input  logic                                 probe_done_i,

    // D and E channels
    output l2_coh_pkg::grant_t                   d_grant_o,
    output logic                                 d_valid_o,
    input  logic                                 d_ready_i,
    input  logic                                 e_valid_i
);
    import l2_coh_pkg::*;

    typedef enum logic [2:0] {IDLE, LOOKUP, PROBE, GRANT, WAIT_E} state_e;

    state_e               state_q;
    state_e               state_d;
    acq_req_t             req_q;
    logic                 hit_q;
    logic                 evict_q;
    logic [WAY_W-1:0]     way_q;
    dir_entry_t           entry_q;
    dir_entry_t           base;
    logic [CORE_ID_W-1:0] req_core;
    logic [NUM_CORES-1:0] req_oh;
    logic                 is_block;
    logic                 is_ntob;
    logic                 d_fire;

    assign req_core = req_q.source[SOURCE_W-1 -: CORE_ID_W];
    assign req_oh   = NUM_CORES'(1) << req_core;
    assign is_block = req_q.opcode == A_ACQUIRE_BLOCK;
    assign is_ntob  = is_block && (req_q.param == GROW_NTOB);
    assign d_fire   = d_valid_o && d_ready_i;

    assign a_ready_o     = state_q == IDLE;
    assign rd_set_o      = req_q.address[LINE_OFS_W +: SET_W];
    assign tag_o         = req_q.address[ADDR_W-1 -: TAG_W];
    assign probe_start_o = state_q == LOOKUP;
    assign req_o         = req_q;
    assign hit_o         = hit_i;     // Live lookup result in the start cycle
    assign entry_o       = entry_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (a_valid_i) state_d = LOOKUP;
            LOOKUP:  state_d = probe_done_i ? GRANT : PROBE;
            PROBE:   if (probe_done_i) state_d = GRANT;
            GRANT:   if (d_fire) state_d = e_valid_i ? IDLE : WAIT_E;
            WAIT_E:  if (e_valid_i) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (a_valid_i && a_ready_o) begin
            req_q <= a_req_i;
        end
        if (state_q == LOOKUP) begin
            hit_q   <= hit_i;
            way_q   <= way_i;
            entry_q <= entry_i;
            evict_q <= evict_i;
        end
    end

    // GrantData for AcquireBlock, plain Grant for AcquirePerm
    assign d_valid_o = state_q == GRANT;
    assign d_grant_o = '{opcode: is_block ? D_GRANT_DATA : D_GRANT,
                         param:  is_ntob ? CAP_TO_B : CAP_TO_T,
                         source: req_q.source};

    // A miss starts from an empty entry
    assign base = hit_q ? entry_q : '0;

    always_comb begin
        wr_entry_o       = base;
        wr_entry_o.valid = 1'b1;
        wr_entry_o.tag   = tag_o;
        if (is_ntob) begin
            // Probed owner is now just a sharer
            wr_entry_o.sharers     = base.owner_valid ? (req_oh | (NUM_CORES'(1) << base.owner_id))
                                                      : (base.sharers | req_oh);
            wr_entry_o.owner_valid = 1'b0;
            wr_entry_o.owner_id    = '0;
        end else begin
            wr_entry_o.sharers     = req_oh;
            wr_entry_o.owner_valid = 1'b1;
            wr_entry_o.owner_id    = req_core;
        end
    end

    assign we_o     = d_fire;
    assign wr_set_o = rd_set_o;
    assign wr_way_o = way_q;
    assign alloc_o  = d_fire && evict_q;   // Victim way reused

endmodule

//--- verif/l2_coh_tb.sv
`timescale 1ns/10ps

module l2_coh_tb;
    import l2_coh_pkg::*;

    localparam int NUM_XACTS      = 18;
    localparam int TIMEOUT_CYCLES = 100 * NUM_XACTS;   // 100 cycles per transaction

    logic                 clk;
    logic                 rst_n;
    acq_req_t             a_req;
    logic                 a_valid;
    logic                 a_ready;
    probe_t               b_probe;
    logic                 b_valid;
    logic                 b_ready;
    logic [2:0]           c_opcode;
    logic [SOURCE_W-1:0]  c_source;
    logic                 c_valid;
    logic                 c_ready;
    grant_t               d_grant;
    logic                 d_valid;
    logic                 d_ready;
    logic                 e_valid;
    logic                 stall;

    // Directory model and the expectation for the running transaction
    dir_entry_t           model_dir [NUM_SETS][NUM_WAYS];
    int                   model_rr;
    logic [NUM_CORES-1:0] exp_mask;
    logic [2:0]           exp_b_opc;
    logic [2:0]           exp_b_param;
    logic [ADDR_W-1:0]    exp_b_addr;
    grant_t               exp_grant;
    int                   exp_set;
    int                   exp_way;
    dir_entry_t           exp_entry;
    logic                 exp_evict;

    int                   cycle = 0;
    logic                 busy = 1'b0;
    int                   a_cyc;
    int                   first_b_cyc;
    int                   d_rise_cyc;
    int                   last_ack_cyc;
    logic [NUM_CORES-1:0] probe_seen;
    logic                 b_hold = 1'b0;
    logic                 d_hold = 1'b0;
    probe_t               b_prev;
    grant_t               d_prev;
    int                   ack_q [$];     // Cores owing a ProbeAck
    int                   ack_due [$];
    int                   next_ack;
    int                   checks = 0;
    int                   errors = 0;
    int                   tests = 0;
    int                   failed_tests = 0;
    int                   test_err0;

    l2_coh_top i_l2_coh_top (
        .clk_i     (clk),      .rst_ni    (rst_n),
        .a_req_i   (a_req),    .a_valid_i (a_valid),  .a_ready_o (a_ready),
        .b_probe_o (b_probe),  .b_valid_o (b_valid),  .b_ready_i (b_ready),
        .c_opcode_i(c_opcode), .c_source_i(c_source), .c_valid_i (c_valid),
        .c_ready_o (c_ready),
        .d_grant_o (d_grant),  .d_valid_o (d_valid),  .d_ready_i (d_ready),
        .e_valid_i (e_valid)
    );

    always #5 clk = ~clk;

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    function automatic int lowest(input logic [NUM_CORES-1:0] mask);
        for (int c = 0; c < NUM_CORES; c++) begin
            if (mask[c]) begin
                return c;
            end
        end
        return -1;
    endfunction

    function automatic logic [ADDR_W-1:0] line_addr(input int tag, input int set_idx);
        return {tag[TAG_W-1:0], set_idx[SET_W-1:0], 6'h10};   // Offset must be dropped
    endfunction

    task automatic predict(input int core, input logic [2:0] opc, input logic [2:0] prm,
                           input logic [ADDR_W-1:0] addr);
        logic [TAG_W-1:0]     tag;
        logic [NUM_CORES-1:0] req_oh;
        logic [NUM_CORES-1:0] own_oh;
        logic                 hit;
        logic                 ntob;
        dir_entry_t           ent;
        tag       = addr[ADDR_W-1 -: TAG_W];
        exp_set   = addr[LINE_OFS_W +: SET_W];
        req_oh    = NUM_CORES'(1) << core;
        ntob      = (opc == A_ACQUIRE_BLOCK) && (prm == GROW_NTOB);
        hit       = 1'b0;
        exp_way   = -1;
        exp_evict = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (exp_way < 0 && model_dir[exp_set][w].valid && model_dir[exp_set][w].tag == tag) begin
                hit     = 1'b1;
                exp_way = w;
            end
        end
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (exp_way < 0 && !model_dir[exp_set][w].valid) begin
                exp_way = w;   // First free way
            end
        end
        if (exp_way < 0) begin
            exp_way   = model_rr;
            exp_evict = 1'b1;
        end
        ent         = model_dir[exp_set][exp_way];
        own_oh      = ent.owner_valid ? (NUM_CORES'(1) << ent.owner_id) : '0;
        exp_b_opc   = (hit && opc == A_ACQUIRE_PERM) ? B_PROBE_PERM : B_PROBE_BLOCK;
        exp_b_param = (hit && ntob) ? CAP_TO_B : CAP_TO_N;
        exp_b_addr  = {ent.tag, exp_set[SET_W-1:0], LINE_OFS_W'(0)};
        if (hit) begin
            exp_mask = (ntob ? own_oh : (ent.sharers | own_oh)) & ~req_oh;
        end else if (exp_evict) begin
            exp_mask = ent.sharers | own_oh;   // Victim holders, requester included
        end else begin
            exp_mask = '0;
        end
        exp_grant = '{opcode: (opc == A_ACQUIRE_BLOCK) ? D_GRANT_DATA : D_GRANT,
                      param:  ntob ? CAP_TO_B : CAP_TO_T,
                      source: {core[1:0], 4'h3}};
        exp_entry = hit ? ent : '0;
        if (ntob) begin
            exp_entry.sharers     = exp_entry.owner_valid ? (req_oh | own_oh)
                                                          : (exp_entry.sharers | req_oh);
            exp_entry.owner_valid = 1'b0;
            exp_entry.owner_id    = '0;
        end else begin
            exp_entry.sharers     = req_oh;
            exp_entry.owner_valid = 1'b1;
            exp_entry.owner_id    = core[1:0];
        end
        exp_entry.valid = 1'b1;
        exp_entry.tag   = tag;
    endtask

    // One full transaction, from Acquire to GrantAck
    task automatic acquire(input int core, input logic [2:0] opc, input logic [2:0] prm,
                           input logic [ADDR_W-1:0] addr);
        predict(core, opc, prm, addr);
        @(posedge clk);
        a_req   <= '{opcode: opc, param: prm, source: {core[1:0], 4'h3}, address: addr};
        a_valid <= 1'b1;
        do @(posedge clk); while (!a_ready);
        a_valid <= 1'b0;
        do @(posedge clk); while (!(d_valid && d_ready));
        repeat ($urandom_range(0, 2)) @(posedge clk);
        e_valid <= 1'b1;
        @(posedge clk);
        e_valid <= 1'b0;
        if (exp_mask == '0) begin
            check_eq("d_valid_o rise cycle", d_rise_cyc, a_cyc + 2);
        end else begin
            check_eq("b_valid_o rise cycle", first_b_cyc, a_cyc + 2);
            check_eq("d_valid_o rise cycle", d_rise_cyc, last_ack_cyc + 1);
        end
        check_eq("probed cores", probe_seen, exp_mask);
        model_dir[exp_set][exp_way] = exp_entry;
        if (exp_evict) begin
            model_rr = (model_rr + 1) % NUM_WAYS;
        end
    endtask

    task automatic test_end(input string name);
        tests++;
        if (errors == test_err0) begin
            $display("PASS  %s", name);
        end else begin
            failed_tests++;
            $display("FAIL  %s (%0d errors)", name, errors - test_err0);
        end
        test_err0 = errors;
    endtask

    // Random back-pressure on B and D
    always @(posedge clk) begin
        b_ready <= stall ? 1'($urandom_range(0, 1)) : 1'b1;
        d_ready <= stall ? 1'($urandom_range(0, 1)) : 1'b1;
    end

    always @(posedge clk) begin
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    // Channel monitor and ProbeAck responder
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (rst_n) begin
            if (busy) begin
                check_eq("a_ready_o", a_ready, 1'b0);
            end
            if (a_valid && a_ready) begin
                busy         = 1'b1;
                a_cyc        = cycle;
                probe_seen   = '0;
                first_b_cyc  = -1;
                d_rise_cyc   = -1;
                last_ack_cyc = -1;
            end
            if (e_valid) begin
                busy = 1'b0;
            end
            if (b_hold) begin
                check_eq("b_valid_o", b_valid, 1'b1);
                check_eq("b_probe_o", b_probe, b_prev);
            end
            if (d_hold) begin
                check_eq("d_valid_o", d_valid, 1'b1);
                check_eq("d_grant_o", d_grant, d_prev);
            end
            if (b_valid && first_b_cyc < 0) first_b_cyc = cycle;
            if (d_valid && d_rise_cyc < 0) d_rise_cyc = cycle;
            if (b_valid && b_ready) begin
                check_eq("b_probe_o.opcode", b_probe.opcode, exp_b_opc);
                check_eq("b_probe_o.param", b_probe.param, exp_b_param);
                check_eq("b_probe_o.address", b_probe.address, exp_b_addr);
                check_eq("b_probe_o.dest", b_probe.dest, lowest(exp_mask & ~probe_seen));
                probe_seen[b_probe.dest] = 1'b1;
                ack_q.push_back(b_probe.dest);
                ack_due.push_back(cycle + $urandom_range(0, 3));
            end
            if (c_valid && c_ready) last_ack_cyc = cycle;
            if (d_valid && d_ready) begin
                check_eq("d_grant_o.opcode", d_grant.opcode, exp_grant.opcode);
                check_eq("d_grant_o.param", d_grant.param, exp_grant.param);
                check_eq("d_grant_o.source", d_grant.source, exp_grant.source);
            end
            b_hold = b_valid && !b_ready;
            d_hold = d_valid && !d_ready;
            b_prev = b_probe;
            d_prev = d_grant;
        end
        if (ack_q.size() > 0 && ack_due[0] <= cycle) begin
            next_ack = ack_q.pop_front();
            void'(ack_due.pop_front());
            c_valid  <= 1'b1;
            c_source <= {next_ack[1:0], 4'h0};
        end else begin
            c_valid <= 1'b0;
        end
    end

    initial begin
        void'($urandom(59));
        clk      = 1'b0;
        rst_n    = 1'b0;
        a_req    = '0;
        a_valid  = 1'b0;
        b_ready  = 1'b1;
        c_opcode = C_PROBE_ACK;
        c_source = '0;
        c_valid  = 1'b0;
        d_ready  = 1'b1;
        e_valid  = 1'b0;
        stall    = 1'b0;
        model_rr = 0;
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                model_dir[s][w] = '0;
            end
        end
        test_err0 = 0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        check_eq("a_ready_o", a_ready, 1'b1);
        check_eq("b_valid_o", b_valid, 1'b0);
        check_eq("d_valid_o", d_valid, 1'b0);
        check_eq("c_ready_o", c_ready, 1'b1);
        test_end("reset state");

        acquire(0, A_ACQUIRE_BLOCK, GROW_NTOB, line_addr('h10, 1));
        test_end("cold miss");

        acquire(0, A_ACQUIRE_BLOCK, GROW_NTOB, line_addr('h20, 2));
        acquire(1, A_ACQUIRE_BLOCK, GROW_NTOB, line_addr('h20, 2));
        acquire(2, A_ACQUIRE_BLOCK, GROW_NTOT, line_addr('h20, 2));   // Probes 0 and 1
        test_end("upgrade by another core");

        acquire(2, A_ACQUIRE_BLOCK, GROW_NTOT, line_addr('h30, 3));
        acquire(3, A_ACQUIRE_PERM, GROW_NTOT, line_addr('h30, 3));
        acquire(0, A_ACQUIRE_BLOCK, GROW_NTOB, line_addr('h30, 3));   // Downgrades core 3
        test_end("AcquirePerm against an owner");

        for (int i = 0; i < 5; i++) begin
            acquire($urandom_range(0, 3), A_ACQUIRE_BLOCK, GROW_NTOB, line_addr('h500 + i, 5));
        end
        acquire($urandom_range(0, 3), A_ACQUIRE_BLOCK, GROW_NTOB, line_addr('h500, 5));
        test_end("eviction");

        stall <= 1'b1;
        acquire(0, A_ACQUIRE_BLOCK, GROW_NTOB, line_addr('h77, 7));
        acquire(1, A_ACQUIRE_BLOCK, GROW_NTOB, line_addr('h77, 7));
        acquire(2, A_ACQUIRE_BLOCK, GROW_NTOT, line_addr('h77, 7));
        acquire(3, A_ACQUIRE_PERM, GROW_NTOT, line_addr('h77, 7));
        acquire(0, A_ACQUIRE_BLOCK, GROW_BTOT, line_addr('h77, 7));
        stall <= 1'b0;
        test_end("back-pressure");

        $display("Tests: %0d run, %0d failed; checks: %0d run, %0d with errors",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
